/* build.f */
+incdir+verilog
verilog/fc_pkg.sv
verilog/fc_ctrl.sv
verilog/fc_counter.sv
verilog/feat_bias_buffer.sv
verilog/dot_unit.sv
verilog/result_packer.sv
verilog/argmax_tracker.sv
verilog/fc_top.sv
tests/fc_tb.sv

/* tests/fc_tb.sv */
// FC engine testbench
`timescale 1ns/1ns
`include "fc_defines.svh"

module fc_tb;

  logic              clk;
  logic              rstn;
  fc_pkg::cmd_t      cmd;
  logic              start;
  fc_pkg::in_beat_t  s_beat;
  logic              s_ready;
  fc_pkg::out_beat_t m_beat;
  logic              m_ready;
  logic              feat_loaded;
  logic              bias_loaded;
  logic              fc_done;
  logic [2:0]        max_idx;

  logic [31:0]   feat_words [`FC_FEAT_WORDS];
  logic [31:0]   bias_words [`FC_BIAS_WORDS];
  logic [31:0]   weight_words [`FC_FEAT_WORDS * `FC_OUT_NUM];
  logic [31:0]   tx_words [`FC_FEAT_WORDS * `FC_OUT_NUM];
  fc_pkg::word_u exp_words [`FC_OUT_WORDS];
  logic [2:0]    exp_idx;
  int            err_count;
  int            timeout_count;

  fc_top dut_i (
    .clk(clk), .rstn(rstn), .cmd(cmd), .start(start), .s_beat(s_beat), .s_ready(s_ready),
    .m_beat(m_beat), .m_ready(m_ready), .feat_loaded(feat_loaded),
    .bias_loaded(bias_loaded), .fc_done(fc_done), .max_idx(max_idx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Compare tasks
  task automatic check_word(input string name, input fc_pkg::word_u got,
                            input fc_pkg::word_u exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error %s: got %h expected %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_idx(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Value errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  //////////////////////////////
  // Reference model
  function automatic int neuron_byte(input int n);
    int  acc;
    byte f;
    byte w;
    acc = byte'(bias_words[n / `FC_LANES][8 * (n % `FC_LANES) +: 8]);
    for (int k = 0; k < `FC_FEAT_WORDS; k++) begin
      for (int l = 0; l < `FC_LANES; l++) begin
        f = byte'(feat_words[k][8 * l +: 8]);
        w = byte'(weight_words[n * `FC_FEAT_WORDS + k][8 * l +: 8]);
        acc = acc + f * w;
      end
    end
    if (acc < 0) return 0;
    acc = acc >>> `FC_FRAC_SHIFT;
    return (acc > 127) ? 127 : acc;
  endfunction

  task automatic compute_model();
    int b;
    int best;
    best = -1;
    for (int n = 0; n < `FC_OUT_NUM; n++) begin
      b = neuron_byte(n);
      exp_words[n / `FC_LANES].raw[8 * (n % `FC_LANES) +: 8] = b[7:0];
      // Strictly greater so the lowest index wins a tie
      if (b > best) begin
        best = b;
        exp_idx = 3'(n);
      end
    end
  endtask

  //////////////////////////////
  // Stimulus
  task automatic issue_cmd(input fc_pkg::cmd_t c);
    @(posedge clk);
    cmd   <= c;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cmd   <= fc_pkg::CMD_NONE;
  endtask

  // Streams tx_words and, in a run, collects and checks the output words
  task automatic stream_words(input fc_pkg::state_t phase, input int n);
    int            sent;
    int            got;
    int            cycles;
    bit            acc;
    bit            held;
    bit            finished;
    fc_pkg::word_u held_word;
    sent = 0;
    got = 0;
    cycles = 0;
    acc = 1'b0;
    held = 1'b0;
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk);
      if (acc) sent++;
      if (!s_beat.valid || acc) begin
        if (sent < n && $urandom_range(9, 0) < 7) begin
          s_beat.data.raw <= tx_words[sent];
          s_beat.valid    <= 1'b1;
        end else begin
          s_beat.valid <= 1'b0;
        end
      end
      m_ready <= ($urandom_range(9, 0) < 6);
      @(negedge clk);
      acc = s_beat.valid && s_ready;
      if (phase != fc_pkg::ST_RUN) begin
        if (sent < n) begin
          check_bit("s_ready", s_ready, 1'b1);
        end else begin
          check_bit("s_ready", s_ready, 1'b0);
          if (phase == fc_pkg::ST_LOAD_FEAT) check_bit("feat_loaded", feat_loaded, 1'b1);
          else check_bit("bias_loaded", bias_loaded, 1'b1);
          finished = 1'b1;
        end
      end else begin
        // Weight input stalls while an output word waits
        if (m_beat.valid && !m_ready) begin
          check_bit("s_ready", s_ready, 1'b0);
        end else begin
          check_bit("s_ready", s_ready, sent < n);
        end
        if (held) begin
          check_bit("m_beat.valid", m_beat.valid, 1'b1);
          check_word("m_beat.data", m_beat.data, held_word);
        end
        held = 1'b0;
        if (m_beat.valid && m_ready) begin
          if (got < `FC_OUT_WORDS) begin
            check_word("m_beat.data", m_beat.data, exp_words[got]);
            check_bit("m_beat.last", m_beat.last, got == `FC_OUT_WORDS - 1);
          end else begin
            err_count++;
            $display("Output word seen after the last word of the run");
          end
          got++;
        end else if (m_beat.valid) begin
          held = 1'b1;
          held_word = m_beat.data;
        end
        if (fc_done) begin
          if (got != `FC_OUT_WORDS) begin
            err_count++;
            $display("fc_done pulsed after %0d of %0d output words", got, `FC_OUT_WORDS);
          end
          check_idx("max_idx", max_idx, exp_idx);
          finished = 1'b1;
        end
      end
      cycles++;
      if (!finished && cycles > 2000) begin
        timeout_count++;
        $display("Timeout while streaming words in state %s", phase.name());
        finish_run();
      end
    end
  endtask

  task automatic load_biases();
    for (int i = 0; i < `FC_BIAS_WORDS; i++) tx_words[i] = bias_words[i];
    issue_cmd(fc_pkg::CMD_BIAS);
    stream_words(fc_pkg::ST_LOAD_BIAS, `FC_BIAS_WORDS);
  endtask

  // Kind 0 random, 1 all -128, 2 all 127, 3 saturating and clamping neurons mixed
  task automatic run_layer(input int kind);
    logic [7:0] f;
    for (int n = 0; n < `FC_OUT_NUM; n++) begin
      for (int k = 0; k < `FC_FEAT_WORDS; k++) begin
        for (int l = 0; l < `FC_LANES; l++) begin
          f = feat_words[k][8 * l +: 8];
          case (kind)
            0: f = 8'($urandom_range(255, 0));
            1: f = 8'h80;
            2: f = 8'h7f;
            default: f = (f[7] ^ n[0]) ? 8'h80 : 8'h7f;
          endcase
          weight_words[n * `FC_FEAT_WORDS + k][8 * l +: 8] = f;
        end
      end
    end
    if (kind != 0) begin
      for (int i = 0; i < `FC_BIAS_WORDS; i++) begin
        bias_words[i] = (kind == 1) ? 32'h80808080 : (kind == 2) ? 32'h7f7f7f7f : 32'h807f807f;
      end
      load_biases();
    end
    compute_model();
    for (int i = 0; i < `FC_FEAT_WORDS * `FC_OUT_NUM; i++) tx_words[i] = weight_words[i];
    issue_cmd(fc_pkg::CMD_RUN);
    stream_words(fc_pkg::ST_RUN, `FC_FEAT_WORDS * `FC_OUT_NUM);
    @(negedge clk);
    check_bit("fc_done", fc_done, 1'b0);
    check_bit("state idle", dut_i.state == fc_pkg::ST_IDLE, 1'b1);
  endtask

  // Run command without both operand sets must leave the engine idle
  task automatic check_ignored();
    issue_cmd(fc_pkg::CMD_RUN);
    repeat (20) begin
      @(negedge clk);
      check_bit("s_ready", s_ready, 1'b0);
      check_bit("m_beat.valid", m_beat.valid, 1'b0);
    end
  endtask

  initial begin
    rstn = 1'b0;
    cmd = fc_pkg::CMD_NONE;
    start = 1'b0;
    s_beat = '0;
    m_ready = 1'b0;
    err_count = 0;
    timeout_count = 0;
    void'($urandom(26589));
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_bit("s_ready", s_ready, 1'b0);
    check_bit("m_beat.valid", m_beat.valid, 1'b0);
    check_bit("fc_done", fc_done, 1'b0);
    check_bit("feat_loaded", feat_loaded, 1'b0);
    check_bit("bias_loaded", bias_loaded, 1'b0);
    check_idx("max_idx", max_idx, 3'd0);
    check_ignored();
    for (int i = 0; i < `FC_FEAT_WORDS; i++) feat_words[i] = $urandom();
    for (int i = 0; i < `FC_FEAT_WORDS; i++) tx_words[i] = feat_words[i];
    issue_cmd(fc_pkg::CMD_FEAT);
    stream_words(fc_pkg::ST_LOAD_FEAT, `FC_FEAT_WORDS);
    check_ignored();
    for (int i = 0; i < `FC_BIAS_WORDS; i++) bias_words[i] = $urandom();
    load_biases();
    repeat (3) run_layer(0);
    run_layer(1);
    run_layer(2);
    run_layer(3);
    finish_run();
  end

endmodule

/* verilog/fc_top.sv */
// FC layer engine top
`timescale 1ns/1ns

module fc_top (
  input  logic              clk,
  input  logic              rstn,
  input  fc_pkg::cmd_t      cmd,
  input  logic              start,
  input  fc_pkg::in_beat_t  s_beat,
  output logic              s_ready,
  output fc_pkg::out_beat_t m_beat,
  input  logic              m_ready,
  output logic              feat_loaded,
  output logic              bias_loaded,
  output logic              fc_done,
  output logic [2:0]        max_idx
);

  fc_pkg::state_t state;
  fc_pkg::word_u  feat_word;
  fc_pkg::word_u  bias_word;
  fc_pkg::acc_t   sum;
  logic [2:0]     word_idx;
  logic [2:0]     neuron_idx;
  logic           word_end;
  logic           neuron_end;
  logic           run_end;
  logic           beat;
  logic           run_beat;
  logic           first;
  logic           start_run;
  logic           sum_valid;
  logic [7:0]     out_byte;
  logic           out_valid;

  //////////////////////////////
  // Strobes
  assign beat      = s_beat.valid && s_ready;
  assign run_beat  = beat && (state == fc_pkg::ST_RUN);
  assign first     = (word_idx == 3'd0);
  assign start_run = start && (cmd == fc_pkg::CMD_RUN) && (state == fc_pkg::ST_IDLE);

  fc_ctrl ctrl_i (
    .clk(clk), .rstn(rstn), .cmd(cmd), .start(start), .s_valid(s_beat.valid),
    .word_end(word_end), .neuron_end(neuron_end), .run_end(run_end),
    .m_valid(m_beat.valid), .m_ready(m_ready), .state(state), .s_ready(s_ready),
    .feat_loaded(feat_loaded), .bias_loaded(bias_loaded), .fc_done(fc_done)
  );

  fc_counter counter_i (
    .clk(clk), .rstn(rstn), .state(state), .beat(beat), .word_idx(word_idx),
    .neuron_idx(neuron_idx), .word_end(word_end), .neuron_end(neuron_end),
    .run_end(run_end)
  );

  feat_bias_buffer buffer_i (
    .clk(clk), .we_feat(beat && (state == fc_pkg::ST_LOAD_FEAT)),
    .we_bias(beat && (state == fc_pkg::ST_LOAD_BIAS)), .word_idx(word_idx),
    .wdata(s_beat.data), .bias_sel(neuron_idx[2]), .feat_word(feat_word),
    .bias_word(bias_word)
  );

  dot_unit dot_i (
    .clk(clk), .rstn(rstn), .beat(run_beat), .first(first), .last(word_end),
    .feat_word(feat_word), .weight_word(s_beat.data), .sum(sum), .sum_valid(sum_valid)
  );

  result_packer packer_i (
    .clk(clk), .rstn(rstn), .sum(sum), .sum_valid(sum_valid), .neuron_idx(neuron_idx),
    .bias_word(bias_word), .run_end(run_end), .m_ready(m_ready), .m_beat(m_beat),
    .out_byte(out_byte), .out_valid(out_valid)
  );

  argmax_tracker argmax_i (
    .clk(clk), .rstn(rstn), .start_run(start_run), .out_byte(out_byte),
    .out_valid(out_valid), .neuron_idx(neuron_idx), .max_idx(max_idx)
  );

endmodule

/* verilog/argmax_tracker.sv */
// Running argmax of output bytes
`timescale 1ns/1ns

module argmax_tracker (
  input  logic       clk,
  input  logic       rstn,
  input  logic       start_run,
  input  logic [7:0] out_byte,
  input  logic       out_valid,
  input  logic [2:0] neuron_idx,
  output logic [2:0] max_idx
);

  logic [7:0] max_val;

  // Outputs are never negative, so zero is a safe starting maximum
  always_ff @(posedge clk) begin
    if (!rstn || start_run) begin
      max_val <= 8'd0;
      max_idx <= 3'd0;
    end else if (out_valid && out_byte > max_val) begin
      // Strictly greater keeps the lowest index on a tie
      max_val <= out_byte;
      max_idx <= neuron_idx;
    end
  end

endmodule

/* verilog/result_packer.sv */
// Bias, ReLU, saturate and pack
`timescale 1ns/1ns
`include "fc_defines.svh"

module result_packer (
  input  logic              clk,
  input  logic              rstn,
  input  fc_pkg::acc_t      sum,
  input  logic              sum_valid,
  input  logic [2:0]        neuron_idx,
  input  fc_pkg::word_u     bias_word,
  input  logic              run_end,
  input  logic              m_ready,
  output fc_pkg::out_beat_t m_beat,
  output logic [7:0]        out_byte,
  output logic              out_valid
);

  logic signed [`FC_ACC_W:0] biased;
  logic signed [`FC_ACC_W:0] scaled;
  fc_pkg::word_u             fill_word;
  fc_pkg::word_u             next_word;
  fc_pkg::word_u             out_word;
  logic                      lane_full;
  logic                      word_valid;
  logic                      word_last;
  logic                      last_pending;

  // One bit wider so the bias add cannot wrap
  always_comb begin
    biased = sum + $signed(bias_word.lane[neuron_idx[1:0]]);
    scaled = biased >>> `FC_FRAC_SHIFT;
    if (biased < 0) out_byte = 8'd0;
    else if (scaled > 127) out_byte = 8'd127;
    else out_byte = scaled[7:0];
    next_word = fill_word;
    next_word.lane[neuron_idx[1:0]] = out_byte;
  end

  assign out_valid = sum_valid;
  assign lane_full = (neuron_idx[1:0] == 2'(`FC_LANES - 1));

  //////////////////////////////
  // Byte packing
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      fill_word <= next_word;
      if (lane_full) out_word <= next_word;
    end
  end

  //////////////////////////////
  // Output stream register
  always_ff @(posedge clk) begin
    if (!rstn) begin
      word_valid   <= 1'b0;
      word_last    <= 1'b0;
      last_pending <= 1'b0;
    end else begin
      if (sum_valid && lane_full) begin
        word_valid   <= 1'b1;
        word_last    <= last_pending;
        last_pending <= 1'b0;
      end else begin
        // Final vector is streaming, so the next full word closes the run
        if (run_end) last_pending <= 1'b1;
        if (m_ready) word_valid <= 1'b0;
      end
    end
  end

  assign m_beat = '{data: out_word, valid: word_valid, last: word_last};

endmodule

/* verilog/dot_unit.sv */
// Four-lane int8 MAC
`timescale 1ns/1ns
`include "fc_defines.svh"

module dot_unit (
  input  logic          clk,
  input  logic          rstn,
  input  logic          beat,
  input  logic          first,
  input  logic          last,
  input  fc_pkg::word_u feat_word,
  input  fc_pkg::word_u weight_word,
  output fc_pkg::acc_t  sum,
  output logic          sum_valid
);

  fc_pkg::acc_t lane_sum;
  fc_pkg::acc_t prod_q;
  fc_pkg::acc_t acc_q;
  logic         prod_valid;
  logic         prod_first;
  logic         prod_last;

  always_comb begin
    lane_sum = '0;
    for (int i = 0; i < `FC_LANES; i++) begin
      lane_sum = lane_sum + $signed(feat_word.lane[i]) * $signed(weight_word.lane[i]);
    end
  end

  //////////////////////////////
  // Product stage
  always_ff @(posedge clk) begin
    if (beat) begin
      prod_q     <= lane_sum;
      prod_first <= first;
      prod_last  <= last;
    end
  end

  //////////////////////////////
  // Accumulate stage
  always_ff @(posedge clk) begin
    if (prod_valid) acc_q <= prod_first ? prod_q : acc_q + prod_q;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      prod_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end else begin
      prod_valid <= beat;
      sum_valid  <= prod_valid && prod_last;
    end
  end

  assign sum = acc_q;

endmodule

/* verilog/feat_bias_buffer.sv */
// Feature and bias register file
`timescale 1ns/1ns
`include "fc_defines.svh"

module feat_bias_buffer (
  input  logic          clk,
  input  logic          we_feat,
  input  logic          we_bias,
  input  logic [2:0]    word_idx,
  input  fc_pkg::word_u wdata,
  input  logic          bias_sel,
  output fc_pkg::word_u feat_word,
  output fc_pkg::word_u bias_word
);

  logic [31:0] feat_mem [`FC_FEAT_WORDS];
  logic [31:0] bias_mem [`FC_BIAS_WORDS];

  always_ff @(posedge clk) begin
    if (we_feat) feat_mem[word_idx] <= wdata.raw;
    // Two bias words, so the low index bit selects
    if (we_bias) bias_mem[word_idx[0]] <= wdata.raw;
  end

  // Combinational reads keep the feature word aligned with its weight beat
  assign feat_word.raw = feat_mem[word_idx];
  assign bias_word.raw = bias_mem[bias_sel];

endmodule

/* verilog/fc_counter.sv */
// Word and neuron counters
`timescale 1ns/1ns
`include "fc_defines.svh"

module fc_counter (
  input  logic           clk,
  input  logic           rstn,
  input  fc_pkg::state_t state,
  input  logic           beat,
  output logic [2:0]     word_idx,
  output logic [2:0]     neuron_idx,
  output logic           word_end,
  output logic           neuron_end,
  output logic           run_end
);

  logic [2:0] vec_idx;
  logic [1:0] drain;
  logic       in_run;

  assign in_run = (state == fc_pkg::ST_RUN);

  // End positions, the consumer qualifies them with the accepted beat
  assign word_end = (in_run || state == fc_pkg::ST_LOAD_FEAT) &&
                    (word_idx == 3'(`FC_FEAT_WORDS - 1));
  // Bias block covers all neurons
  assign neuron_end = (state == fc_pkg::ST_LOAD_BIAS) &&
                      (word_idx == 3'(`FC_BIAS_WORDS - 1));
  assign run_end = in_run && word_end && (vec_idx == 3'(`FC_OUT_NUM - 1));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      word_idx   <= '0;
      vec_idx    <= '0;
      drain      <= '0;
      neuron_idx <= '0;
    end else begin
      drain <= {drain[0], beat && in_run && word_end};
      if (state == fc_pkg::ST_IDLE) begin
        word_idx <= '0;
        vec_idx  <= '0;
      end else if (beat) begin
        word_idx <= (word_end || neuron_end) ? 3'd0 : word_idx + 3'd1;
        if (in_run && word_end) vec_idx <= run_end ? 3'd0 : vec_idx + 3'd1;
      end
      // Neuron index moves two cycles after its vector ends, in step with the dot unit
      if (drain[1]) begin
        neuron_idx <= (neuron_idx == 3'(`FC_OUT_NUM - 1)) ? 3'd0 : neuron_idx + 3'd1;
      end
    end
  end

endmodule

/* verilog/fc_ctrl.sv */
// Layer control FSM
`timescale 1ns/1ns

module fc_ctrl (
  input  logic           clk,
  input  logic           rstn,
  input  fc_pkg::cmd_t   cmd,
  input  logic           start,
  input  logic           s_valid,
  input  logic           word_end,
  input  logic           neuron_end,
  input  logic           run_end,
  input  logic           m_valid,
  input  logic           m_ready,
  output fc_pkg::state_t state,
  output logic           s_ready,
  output logic           feat_loaded,
  output logic           bias_loaded,
  output logic           fc_done
);

  logic accept;
  logic weights_done;

  assign accept = s_valid && s_ready;

  always_comb begin
    case (state)
      fc_pkg::ST_LOAD_FEAT,
      fc_pkg::ST_LOAD_BIAS: s_ready = 1'b1;
      // Stall weights while a full word waits downstream
      fc_pkg::ST_RUN: s_ready = !weights_done && !(m_valid && !m_ready);
      default: s_ready = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state        <= fc_pkg::ST_IDLE;
      feat_loaded  <= 1'b0;
      bias_loaded  <= 1'b0;
      weights_done <= 1'b0;
      fc_done      <= 1'b0;
    end else begin
      fc_done <= 1'b0;
      case (state)
        fc_pkg::ST_IDLE: begin
          weights_done <= 1'b0;
          if (start) begin
            case (cmd)
              fc_pkg::CMD_FEAT: state <= fc_pkg::ST_LOAD_FEAT;
              fc_pkg::CMD_BIAS: state <= fc_pkg::ST_LOAD_BIAS;
              // Run only once both operand sets are present
              fc_pkg::CMD_RUN: begin
                if (feat_loaded && bias_loaded) state <= fc_pkg::ST_RUN;
              end
              default: ;
            endcase
          end
        end
        fc_pkg::ST_LOAD_FEAT: begin
          if (accept && word_end) begin
            state       <= fc_pkg::ST_IDLE;
            feat_loaded <= 1'b1;
          end
        end
        fc_pkg::ST_LOAD_BIAS: begin
          if (accept && neuron_end) begin
            state       <= fc_pkg::ST_IDLE;
            bias_loaded <= 1'b1;
          end
        end
        fc_pkg::ST_RUN: begin
          if (accept && run_end) weights_done <= 1'b1;
          // Earlier words have left before the final weight beat
          if (weights_done && m_valid && m_ready) begin
            state   <= fc_pkg::ST_IDLE;
            fc_done <= 1'b1;
          end
        end
        default: state <= fc_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

/* verilog/fc_pkg.sv */
// FC engine types
`include "fc_defines.svh"

package fc_pkg;

  // One 32-bit word, seen raw or as four int8 lanes
  typedef union packed {
    logic [31:0] raw;
    logic [`FC_LANES-1:0][7:0] lane;
  } word_u;

  // Input stream beat
  typedef struct packed {
    word_u data;
    logic valid;
  } in_beat_t;

  // Output stream beat
  typedef struct packed {
    word_u data;
    logic valid;
    logic last;
  } out_beat_t;

  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_FEAT,
    CMD_BIAS,
    CMD_RUN
  } cmd_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD_FEAT,
    ST_LOAD_BIAS,
    ST_RUN
  } state_t;

  typedef logic signed [`FC_ACC_W-1:0] acc_t;

endpackage

/* verilog/fc_defines.svh */
// FC layer sizes
`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

// Feature words per vector, 32 int8 features
`define FC_FEAT_WORDS 8

// Output neurons and bytes per 32-bit word
`define FC_OUT_NUM 8
`define FC_LANES 4

// One bias byte per neuron, four per word
`define FC_BIAS_WORDS 2
`define FC_OUT_WORDS 2

// Fixed-point scaling and accumulator width
`define FC_FRAC_SHIFT 6
`define FC_ACC_W 20

`endif
